//--- tb.f
hdl/pu_riscv_mem_pkg.sv
hdl/pu_riscv_memmisaligned.sv
hdl/pu_riscv_axi4lite_master.sv
hdl/pu_riscv_dmem_ctrl.sv
hdl/pu_riscv_dmem_top.sv
verif/pu_riscv_dmem_props.sv
verif/pu_riscv_dmem_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= pu_riscv_dmem_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# a failing run ends in $fatal, which gives a nonzero exit status.
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

//--- verif/pu_riscv_dmem_tb.sv
// XLEN 64 with RVC; slave memory covers bytes 0 to 2047 only, random seed is fixed.
`timescale 1ns/1ps
`default_nettype none

module pu_riscv_dmem_tb;

  import pu_riscv_mem_pkg::*;

  localparam int XLEN       = 64;
  localparam int HAS_RVC    = 1;
  localparam int MEM_BYTES  = 2048;
  localparam int N_RANDOM   = 400;
  localparam int N_DIRECTED = 76;
  localparam int TIMEOUT    = 20 * (N_RANDOM + N_DIRECTED);

  logic clk = 1'b0;
  logic reset;
  logic req_valid, req_ready, req_instr, req_we, req_signed;
  logic [XLEN-1:0] req_adr, req_wdata, rsp_rdata;
  mem_size_t req_size;
  logic rsp_valid, rsp_err;
  logic awvalid, awready, wvalid, wready, bvalid, bready, arvalid, arready, rvalid, rready;
  logic [XLEN-1:0] awaddr, wdata, araddr, rdata;
  logic [XLEN/8-1:0] wstrb;
  axi_resp_t bresp, rresp;

  integer seed = 32'h8dcd_29d4;
  // slave delays use their own stream so the request sequence stays fixed.
  integer slave_seed = 32'h8dcd_29d4 ^ 32'h0000_5a5a;
  int cycle_cnt = 0;
  int bus_cnt = 0;
  // edges that saw any AXI valid high.
  int valid_cnt = 0;
  int rsp_cnt = 0;
  int req_cnt = 0;

  // slave memory and the byte-wide shadow model.
  logic [63:0] mem [0:255];
  logic [7:0]  shadow [0:MEM_BYTES-1];

  // slave channel state.
  logic aw_have = 0, w_have = 0, ar_have = 0, b_rdy_q = 0, r_rdy_q = 0;
  int aw_wait = 0, w_wait = 0, b_wait = 0, ar_wait = 0, r_wait = 0;
  logic [XLEN-1:0] aw_lat, w_lat, ar_lat;
  logic [XLEN/8-1:0] s_lat;

  pu_riscv_dmem_top #(.XLEN(XLEN), .HAS_RVC(HAS_RVC)) i_dut (
    .clk_i(clk), .reset_i(reset),
    .req_valid_i(req_valid), .req_ready_o(req_ready), .req_instr_i(req_instr),
    .req_we_i(req_we), .req_adr_i(req_adr), .req_size_i(req_size),
    .req_signed_i(req_signed), .req_wdata_i(req_wdata),
    .rsp_valid_o(rsp_valid), .rsp_rdata_o(rsp_rdata), .rsp_err_o(rsp_err),
    .awvalid_o(awvalid), .awready_i(awready), .awaddr_o(awaddr),
    .wvalid_o(wvalid), .wready_i(wready), .wdata_o(wdata), .wstrb_o(wstrb),
    .bvalid_i(bvalid), .bready_o(bready), .bresp_i(bresp),
    .arvalid_o(arvalid), .arready_i(arready), .araddr_o(araddr),
    .rvalid_i(rvalid), .rready_o(rready), .rdata_i(rdata), .rresp_i(rresp)
  );

  always #5 clk = ~clk;

  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input logic [XLEN-1:0] exp, act);
    if (exp !== act) report_fail($sformatf("** Error %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_err(input string name, input logic exp, act);
    if (exp !== act) report_fail($sformatf("** Error %s: expected %b, actual %b", name, exp, act));
  endtask

  task automatic check_resp(input string name, input axi_resp_t exp, act);
    if (exp !== act) report_fail($sformatf("** Error %s: expected %h, actual %h", name, exp, act));
  endtask

  // every word gets its own index in each byte.
  function automatic logic [63:0] fill_word(input int idx);
    logic [7:0] b;
    b = idx[7:0];
    return {8{b}} ^ 64'h0123_4567_89ab_cdef;
  endfunction

  function automatic int rand_delay();
    return int'($unsigned($random(slave_seed)) % 4);
  endfunction

  // natural alignment for data, halfword alignment for fetches with RVC.
  function automatic logic bad_access(input logic instr, input logic [XLEN-1:0] adr,
                                      input mem_size_t size);
    if (size > DWORD) return 1'b1;
    if (instr) return (HAS_RVC != 0) ? adr[0] : (adr[1:0] != 2'b00);
    case (size)
      BYTE:    return 1'b0;
      HWORD:   return adr[0];
      WORD:    return adr[1:0] != 2'b00;
      default: return adr[2:0] != 3'b000;
    endcase
  endfunction

  function automatic logic [XLEN-1:0] extend(input logic [XLEN-1:0] raw, input mem_size_t size,
                                             input logic sgn);
    case (size)
      BYTE:    return sgn ? {{56{raw[7]}}, raw[7:0]} : {56'b0, raw[7:0]};
      HWORD:   return sgn ? {{48{raw[15]}}, raw[15:0]} : {48'b0, raw[15:0]};
      WORD:    return sgn ? {{32{raw[31]}}, raw[31:0]} : {32'b0, raw[31:0]};
      default: return raw;
    endcase
  endfunction

  // AXI4-Lite slave; all outputs change 1 ns after the edge.
  always begin
    @(posedge clk);
    #1;
    if (awready) begin
      awready = 1'b0;
      aw_have = 1'b1;
      aw_wait = rand_delay();
    end else if (awvalid && !aw_have) begin
      if (aw_wait == 0) begin
        awready = 1'b1;
        aw_lat  = awaddr;
      end else aw_wait--;
    end
    if (wready) begin
      wready = 1'b0;
      w_have = 1'b1;
      w_wait = rand_delay();
    end else if (wvalid && !w_have) begin
      if (w_wait == 0) begin
        wready = 1'b1;
        w_lat  = wdata;
        s_lat  = wstrb;
      end else w_wait--;
    end
    if (bvalid && b_rdy_q) begin
      bvalid = 1'b0;
    end else if (aw_have && w_have && !bvalid) begin
      if (b_wait == 0) begin
        // out-of-range writes leave memory alone.
        if (aw_lat < MEM_BYTES) begin
          for (int b = 0; b < 8; b++) begin
            if (s_lat[b]) mem[aw_lat[10:3]][8*b +: 8] = w_lat[8*b +: 8];
          end
        end
        bresp   = (aw_lat < MEM_BYTES) ? RESP_OKAY : RESP_SLVERR;
        bvalid  = 1'b1;
        aw_have = 1'b0;
        w_have  = 1'b0;
        b_wait  = rand_delay();
      end else b_wait--;
    end
    if (arready) begin
      arready = 1'b0;
      ar_have = 1'b1;
      ar_wait = rand_delay();
    end else if (arvalid && !ar_have) begin
      if (ar_wait == 0) begin
        arready = 1'b1;
        ar_lat  = araddr;
      end else ar_wait--;
    end
    if (rvalid && r_rdy_q) begin
      rvalid = 1'b0;
    end else if (ar_have && !rvalid) begin
      if (r_wait == 0) begin
        rdata   = (ar_lat < MEM_BYTES) ? mem[ar_lat[10:3]] : '0;
        rresp   = (ar_lat < MEM_BYTES) ? RESP_OKAY : RESP_SLVERR;
        rvalid  = 1'b1;
        ar_have = 1'b0;
        r_wait  = rand_delay();
      end else r_wait--;
    end
    b_rdy_q = bready;
    r_rdy_q = rready;
  end

  // address handshakes, bus valids and response pulses, sampled at the edge.
  always @(posedge clk) begin
    if ((awvalid && awready) || (arvalid && arready)) bus_cnt++;
    if (awvalid || wvalid || arvalid) valid_cnt++;
    if (rsp_valid) rsp_cnt++;
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT) report_fail("timeout: the DUT stopped answering requests");
  end

  // one request through the CPU port, checked against the shadow model.
  task automatic run_req(input string name, input logic instr, we, input logic [XLEN-1:0] adr,
                         input mem_size_t size, input logic sgn, input logic [XLEN-1:0] wd);
    logic bad, oob, rd;
    logic [XLEN-1:0] raw, exp_data;
    int base, off, lat, bus_before, valid_before;
    bad = bad_access(instr, adr, size);
    oob = adr >= MEM_BYTES;
    rd = instr || !we;
    base = int'(adr[10:0]) & ~7;
    off = int'(adr[2:0]);
    raw = '0;
    // bytes past the end of the bus word never reach the CPU.
    for (int b = 0; b < 8; b++) begin
      if (off + b < 8) raw[8*b +: 8] = shadow[base + off + b];
    end
    exp_data = (bad || oob || !rd) ? '0 : extend(raw, size, sgn && !instr);
    bus_before = bus_cnt;
    valid_before = valid_cnt;
    req_valid = 1'b1;
    req_instr = instr;
    req_we = we;
    req_adr = adr;
    req_size = size;
    req_signed = sgn;
    req_wdata = wd;
    while (!req_ready) begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);
    #1;
    req_valid = 1'b0;
    lat = 1;
    while (!rsp_valid) begin
      @(posedge clk);
      #1;
      lat++;
    end
    req_cnt++;
    check_err(name, bad || oob, rsp_err);
    check_data(name, exp_data, rsp_rdata);
    if (bad) begin
      if (lat != 1) begin
        report_fail($sformatf("** Error %s latency: expected 1, actual %0d", name, lat));
      end
      // a transfer started in the check cycle shows its valid one edge later.
      @(posedge clk);
      #1;
      if (valid_cnt != valid_before) report_fail("a rejected request started a bus transfer");
    end else begin
      check_resp(name, oob ? RESP_SLVERR : RESP_OKAY, i_dut.bus_resp);
      if (bus_cnt != bus_before + 1) report_fail("an aligned request did not make one transfer");
      if (!rd && !oob) begin
        for (int b = 0; b < (1 << size); b++) shadow[base + off + b] = wd[8*b +: 8];
      end
    end
  endtask

  function automatic logic [XLEN-1:0] rand_word();
    return {$random(seed), $random(seed)};
  endfunction

  function automatic logic [XLEN-1:0] rand_adr(input mem_size_t size);
    return XLEN'(($unsigned($random(seed)) % MEM_BYTES) & ~((1 << size) - 1));
  endfunction

  initial begin
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] w;
    mem_size_t sz;
    int kind;
    for (int i = 0; i < 256; i++) begin
      mem[i] = fill_word(i);
      for (int b = 0; b < 8; b++) shadow[8*i + b] = mem[i][8*b +: 8];
    end
    req_valid = 0;
    req_instr = 0;
    req_we = 0;
    req_adr = '0;
    req_size = BYTE;
    req_signed = 0;
    req_wdata = '0;
    awready = 0;
    wready = 0;
    bvalid = 0;
    bresp = RESP_OKAY;
    arready = 0;
    rvalid = 0;
    rdata = '0;
    rresp = RESP_OKAY;
    reset = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
    // stores of every size read back signed and unsigned.
    for (int s = 0; s < 4; s++) begin
      for (int k = 0; k < 4; k++) begin
        sz = mem_size_t'(s);
        a = rand_adr(sz);
        run_req("roundtrip store", 0, 1, a, sz, 0, rand_word());
        run_req("roundtrip load signed", 0, 0, a, sz, 1, '0);
        run_req("roundtrip load unsigned", 0, 0, a, sz, 0, '0);
      end
    end
    // neighbouring bytes of a narrow store stay intact.
    for (int s = 0; s < 4; s++) begin
      sz = mem_size_t'(s);
      a = rand_adr(sz);
      run_req("lanes before", 0, 0, a & ~64'h7, DWORD, 0, '0);
      run_req("lanes store", 0, 1, a, sz, 0, rand_word());
      run_req("lanes after", 0, 0, a & ~64'h7, DWORD, 0, '0);
    end
    // rejected accesses, then the legal halfword fetch boundaries.
    run_req("misaligned hword", 0, 0, 64'h41, HWORD, 0, '0);
    run_req("misaligned word", 0, 0, 64'h42, WORD, 1, '0);
    run_req("misaligned dword", 0, 0, 64'h44, DWORD, 0, '0);
    run_req("misaligned store", 0, 1, 64'h81, WORD, 0, rand_word());
    for (int s = 4; s < 8; s++) run_req("illegal size", 0, 0, 64'h80, mem_size_t'(s), 0, '0);
    run_req("fetch odd", 1, 0, 64'h101, WORD, 0, '0);
    run_req("fetch odd hword", 1, 0, 64'h103, HWORD, 0, '0);
    run_req("fetch halfword boundary", 1, 0, 64'h102, WORD, 0, '0);
    run_req("fetch end of word", 1, 0, 64'h106, WORD, 0, '0);
    // addresses past the slave memory.
    run_req("oob store", 0, 1, MEM_BYTES + 8, DWORD, 0, rand_word());
    run_req("oob load", 0, 0, MEM_BYTES + 8, DWORD, 0, '0);
    run_req("oob store high", 0, 1, 64'h8000_0000, WORD, 0, rand_word());
    run_req("oob load high", 0, 0, 64'h8000_0000, WORD, 1, '0);
    // random mix under random slave delays.
    for (int n = 0; n < N_RANDOM; n++) begin
      kind = int'($unsigned($random(seed)) % 8);
      sz = mem_size_t'($unsigned($random(seed)) % 4);
      if (($unsigned($random(seed)) % 16) == 0) begin
        sz = mem_size_t'(4 + $unsigned($random(seed)) % 4);
      end
      a = rand_adr(sz);
      w = rand_word();
      case ($unsigned($random(seed)) % 8)
        0: a = a | 64'h1;
        1: a = a + MEM_BYTES;
        default: ;
      endcase
      if (kind < 3) run_req("random store", 0, 1, a, sz, 0, w);
      else if (kind < 7) run_req("random load", 0, 0, a, sz, kind[0], '0);
      else run_req("random fetch", 1, 0, a, sz, 1, '0);
    end
    repeat (2) @(posedge clk);
    #1;
    if (rsp_cnt != req_cnt) report_fail("the number of responses differs from the requests");
    for (int i = 0; i < 256; i++) begin
      for (int b = 0; b < 8; b++) w[8*b +: 8] = shadow[8*i + b];
      check_data("memory contents", w, mem[i]);
    end
    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/pu_riscv_dmem_props.sv
// bound into pu_riscv_dmem_top; checks are off while reset_i is high.
`timescale 1ns/1ps
`default_nettype none

module pu_riscv_dmem_props (
  input wire clk_i,
  input wire reset_i,
  input wire req_valid_i,
  input wire req_ready_o,
  input wire rsp_valid_o,
  input wire rsp_err_o,
  input wire awvalid_o,
  input wire awready_i,
  input wire wvalid_o,
  input wire wready_i,
  input wire arvalid_o,
  input wire arready_i
);

  // valids hold until their ready.
  aw_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    awvalid_o && !awready_i |=> awvalid_o) else $error("awvalid dropped before awready");
  w_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    wvalid_o && !wready_i |=> wvalid_o) else $error("wvalid dropped before wready");
  ar_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    arvalid_o && !arready_i |=> arvalid_o) else $error("arvalid dropped before arready");

  // response is a single cycle pulse.
  rsp_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
    rsp_valid_o |=> !rsp_valid_o) else $error("rsp_valid lasted two cycles");

  // a rejected request leaves the bus quiet.
  quiet_bus: assert property (@(posedge clk_i) disable iff (reset_i)
    (req_valid_i && req_ready_o) ##1 (rsp_valid_o && rsp_err_o)
      |-> !(awvalid_o || wvalid_o || arvalid_o) ##1 !(awvalid_o || wvalid_o || arvalid_o))
    else $error("bus valid raised for a rejected request");

endmodule

bind pu_riscv_dmem_top pu_riscv_dmem_props i_props (
  .clk_i(clk_i), .reset_i(reset_i), .req_valid_i(req_valid_i), .req_ready_o(req_ready_o),
  .rsp_valid_o(rsp_valid_o), .rsp_err_o(rsp_err_o), .awvalid_o(awvalid_o),
  .awready_i(awready_i), .wvalid_o(wvalid_o), .wready_i(wready_i),
  .arvalid_o(arvalid_o), .arready_i(arready_i)
);

`default_nettype wire

//--- hdl/pu_riscv_dmem_top.sv
// XLEN is 32 or 64; AXI4-Lite data width equals XLEN and addresses go out word aligned.
`timescale 1ns/1ps
`default_nettype none

module pu_riscv_dmem_top #(
  parameter int XLEN    = 64,
  parameter int HAS_RVC = 1
) (
  input  wire                         clk_i,
  input  wire                         reset_i,

  // CPU port.
  input  wire                         req_valid_i,
  output logic                        req_ready_o,
  input  wire                         req_instr_i,
  input  wire                         req_we_i,
  input  wire  [XLEN-1:0]             req_adr_i,
  input  wire  pu_riscv_mem_pkg::mem_size_t req_size_i,
  input  wire                         req_signed_i,
  input  wire  [XLEN-1:0]             req_wdata_i,
  output logic                        rsp_valid_o,
  output logic [XLEN-1:0]             rsp_rdata_o,
  output logic                        rsp_err_o,

  // AXI4-Lite master port.
  output logic                        awvalid_o,
  input  wire                         awready_i,
  output logic [XLEN-1:0]             awaddr_o,
  output logic                        wvalid_o,
  input  wire                         wready_i,
  output logic [XLEN-1:0]             wdata_o,
  output logic [XLEN/8-1:0]           wstrb_o,
  input  wire                         bvalid_i,
  output logic                        bready_o,
  input  wire  pu_riscv_mem_pkg::axi_resp_t bresp_i,
  output logic                        arvalid_o,
  input  wire                         arready_i,
  output logic [XLEN-1:0]             araddr_o,
  input  wire                         rvalid_i,
  output logic                        rready_o,
  input  wire  [XLEN-1:0]             rdata_i,
  input  wire  pu_riscv_mem_pkg::axi_resp_t rresp_i
);

  import pu_riscv_mem_pkg::*;

  // check strobe and result.
  logic              accept;
  logic              misaligned;

  // controller to master.
  logic              bus_start;
  logic              bus_we;
  logic [XLEN-1:0]   bus_adr;
  logic [XLEN-1:0]   bus_wdata;
  logic [XLEN/8-1:0] bus_strb;
  logic              bus_done;
  logic [XLEN-1:0]   bus_rdata;
  axi_resp_t         bus_resp;

  pu_riscv_dmem_ctrl #(
    .XLEN (XLEN)
  ) i_ctrl (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .req_instr_i  (req_instr_i),
    .req_we_i     (req_we_i),
    .req_adr_i    (req_adr_i),
    .req_size_i   (req_size_i),
    .req_signed_i (req_signed_i),
    .req_wdata_i  (req_wdata_i),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_rdata_o  (rsp_rdata_o),
    .rsp_err_o    (rsp_err_o),
    .accept_o     (accept),
    .misaligned_i (misaligned),
    .start_o      (bus_start),
    .we_o         (bus_we),
    .adr_o        (bus_adr),
    .wdata_o      (bus_wdata),
    .strb_o       (bus_strb),
    .done_i       (bus_done),
    .rdata_i      (bus_rdata),
    .resp_i       (bus_resp)
  );

  // request fields are held by the CPU during acceptance.
  pu_riscv_memmisaligned #(
    .XLEN    (XLEN),
    .HAS_RVC (HAS_RVC)
  ) i_misaligned (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .instr_i      (req_instr_i),
    .req_i        (accept),
    .adr_i        (req_adr_i),
    .size_i       (req_size_i),
    .misaligned_o (misaligned)
  );

  pu_riscv_axi4lite_master #(
    .XLEN (XLEN)
  ) i_axi (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .start_i   (bus_start),
    .we_i      (bus_we),
    .adr_i     (bus_adr),
    .wdata_i   (bus_wdata),
    .strb_i    (bus_strb),
    .done_o    (bus_done),
    .rdata_o   (bus_rdata),
    .resp_o    (bus_resp),
    .awvalid_o (awvalid_o),
    .awready_i (awready_i),
    .awaddr_o  (awaddr_o),
    .wvalid_o  (wvalid_o),
    .wready_i  (wready_i),
    .wdata_o   (wdata_o),
    .wstrb_o   (wstrb_o),
    .bvalid_i  (bvalid_i),
    .bready_o  (bready_o),
    .bresp_i   (bresp_i),
    .arvalid_o (arvalid_o),
    .arready_i (arready_i),
    .araddr_o  (araddr_o),
    .rvalid_i  (rvalid_i),
    .rready_o  (rready_o),
    .rdata_i   (rdata_i),
    .rresp_i   (rresp_i)
  );

endmodule

`default_nettype wire

//--- hdl/pu_riscv_dmem_ctrl.sv
// one request in flight; response outputs are only meaningful while rsp_valid_o is high.
`timescale 1ns/1ps
`default_nettype none

module pu_riscv_dmem_ctrl #(
  parameter int XLEN = 64
) (
  input  wire                         clk_i,
  input  wire                         reset_i,

  // CPU request port.
  input  wire                         req_valid_i,
  output logic                        req_ready_o,
  input  wire                         req_instr_i,
  input  wire                         req_we_i,
  input  wire  [XLEN-1:0]             req_adr_i,
  input  wire  pu_riscv_mem_pkg::mem_size_t req_size_i,
  input  wire                         req_signed_i,
  input  wire  [XLEN-1:0]             req_wdata_i,

  // CPU response, single cycle pulse.
  output logic                        rsp_valid_o,
  output logic [XLEN-1:0]             rsp_rdata_o,
  output logic                        rsp_err_o,

  // misalignment check.
  output logic                        accept_o,
  input  wire                         misaligned_i,

  // bus master side.
  output logic                        start_o,
  output logic                        we_o,
  output logic [XLEN-1:0]             adr_o,
  output logic [XLEN-1:0]             wdata_o,
  output logic [XLEN/8-1:0]           strb_o,
  input  wire                         done_i,
  input  wire  [XLEN-1:0]             rdata_i,
  input  wire  pu_riscv_mem_pkg::axi_resp_t resp_i
);

  import pu_riscv_mem_pkg::*;

  localparam int STRB_W = XLEN / 8;
  localparam int LSB    = $clog2(STRB_W);

  localparam logic [1:0] S_IDLE  = 2'd0;
  localparam logic [1:0] S_CHECK = 2'd1;
  localparam logic [1:0] S_BUS   = 2'd2;

  logic [1:0]        state;
  logic [1:0]        state_nxt;
  logic              instr_q;
  logic              we_q;
  logic [XLEN-1:0]   adr_q;
  mem_size_t         size_q;
  logic              signed_q;
  logic [XLEN-1:0]   wdata_q;
  logic [LSB-1:0]    off;
  logic [STRB_W-1:0] size_mask;
  logic [XLEN-1:0]   rd_shift;
  logic [XLEN-1:0]   rd_ext;
  logic              sext;

  // handshake completes only on a ready cycle.
  assign accept_o = req_valid_i & req_ready_o;

  // request is frozen here for the rest of the access.
  always_ff @(posedge clk_i) begin
    if (accept_o) begin
      instr_q  <= req_instr_i;
      we_q     <= req_we_i;
      adr_q    <= req_adr_i;
      size_q   <= req_size_i;
      signed_q <= req_signed_i;
      wdata_q  <= req_wdata_i;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      S_IDLE:  if (accept_o) state_nxt = S_CHECK;
      // misaligned accesses end here, the rest go to the bus.
      S_CHECK: state_nxt = misaligned_i ? S_IDLE : S_BUS;
      S_BUS:   if (done_i) state_nxt = S_IDLE;
      default: state_nxt = S_IDLE;
    endcase
  end

  // ready is registered so it stays low through reset.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state       <= S_IDLE;
      req_ready_o <= 1'b0;
    end else begin
      state       <= state_nxt;
      req_ready_o <= (state_nxt == S_IDLE);
    end
  end

  // byte offset inside the bus word.
  assign off = adr_q[LSB-1:0];

  // one strobe bit per byte of the access.
  always_comb begin
    case (size_q)
      BYTE:    size_mask = STRB_W'(8'h01);
      HWORD:   size_mask = STRB_W'(8'h03);
      WORD:    size_mask = STRB_W'(8'h0f);
      default: size_mask = STRB_W'(8'hff);
    endcase
  end

  // bus transfer starts in the check cycle of a good access.
  assign start_o = (state == S_CHECK) & ~misaligned_i;
  // fetches are always reads.
  assign we_o    = we_q & ~instr_q;
  // address goes out aligned to the bus word.
  assign adr_o   = {adr_q[XLEN-1:LSB], {LSB{1'b0}}};
  assign wdata_o = wdata_q << {off, 3'b000};
  assign strb_o  = size_mask << off;

  // move the addressed bytes down to bit 0.
  assign rd_shift = rdata_i >> {off, 3'b000};
  // fetches never sign-extend.
  assign sext     = signed_q & ~instr_q;

  always_comb begin
    case (size_q)
      BYTE: begin
        rd_ext = sext ? XLEN'($signed(rd_shift[7:0])) : XLEN'(rd_shift[7:0]);
      end
      HWORD: begin
        rd_ext = sext ? XLEN'($signed(rd_shift[15:0])) : XLEN'(rd_shift[15:0]);
      end
      WORD: begin
        rd_ext = sext ? XLEN'($signed(rd_shift[31:0])) : XLEN'(rd_shift[31:0]);
      end
      default: rd_ext = rd_shift;
    endcase
  end

  // misaligned answer in the check cycle, bus answer with done.
  assign rsp_valid_o = ((state == S_CHECK) & misaligned_i) | ((state == S_BUS) & done_i);

  // any response other than okay is reported as an error.
  assign rsp_err_o = (state == S_CHECK) ? misaligned_i : (resp_i != RESP_OKAY);

  // data only for successful reads, zero otherwise.
  assign rsp_rdata_o = ((state == S_BUS) && !we_o && (resp_i == RESP_OKAY)) ? rd_ext : '0;

endmodule

`default_nettype wire

//--- hdl/pu_riscv_axi4lite_master.sv
// one transfer at a time, no bursts; start_i is only honoured while the master is idle.
`timescale 1ns/1ps
`default_nettype none

module pu_riscv_axi4lite_master #(
  parameter int XLEN = 64
) (
  input  wire                         clk_i,
  input  wire                         reset_i,

  // transfer request from the controller.
  input  wire                         start_i,
  input  wire                         we_i,
  input  wire  [XLEN-1:0]             adr_i,
  input  wire  [XLEN-1:0]             wdata_i,
  input  wire  [XLEN/8-1:0]           strb_i,
  output logic                        done_o,
  output logic [XLEN-1:0]             rdata_o,
  output pu_riscv_mem_pkg::axi_resp_t resp_o,

  // write address and write data channels.
  output logic                        awvalid_o,
  input  wire                         awready_i,
  output logic [XLEN-1:0]             awaddr_o,
  output logic                        wvalid_o,
  input  wire                         wready_i,
  output logic [XLEN-1:0]             wdata_o,
  output logic [XLEN/8-1:0]           wstrb_o,

  // write response channel.
  input  wire                         bvalid_i,
  output logic                        bready_o,
  input  wire  pu_riscv_mem_pkg::axi_resp_t bresp_i,

  // read address and read data channels.
  output logic                        arvalid_o,
  input  wire                         arready_i,
  output logic [XLEN-1:0]             araddr_o,
  input  wire                         rvalid_i,
  output logic                        rready_o,
  input  wire  [XLEN-1:0]             rdata_i,
  input  wire  pu_riscv_mem_pkg::axi_resp_t rresp_i
);

  localparam logic [2:0] S_IDLE  = 3'd0;
  localparam logic [2:0] S_WRITE = 3'd1;
  localparam logic [2:0] S_BRESP = 3'd2;
  localparam logic [2:0] S_READ  = 3'd3;
  localparam logic [2:0] S_RRESP = 3'd4;

  logic [2:0]      state;
  logic [XLEN-1:0] adr_q;

  // same address register serves both address channels.
  assign awaddr_o = adr_q;
  assign araddr_o = adr_q;

  // payload is captured on start and held for the transfer.
  always_ff @(posedge clk_i) begin
    if ((state == S_IDLE) && start_i) begin
      adr_q   <= adr_i;
      wdata_o <= wdata_i;
      wstrb_o <= strb_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state     <= S_IDLE;
      awvalid_o <= 1'b0;
      wvalid_o  <= 1'b0;
      bready_o  <= 1'b0;
      arvalid_o <= 1'b0;
      rready_o  <= 1'b0;
      done_o    <= 1'b0;
    end else begin
      done_o <= 1'b0;
      case (state)
        S_IDLE: begin
          if (start_i && we_i) begin
            // address and data go out together.
            awvalid_o <= 1'b1;
            wvalid_o  <= 1'b1;
            state     <= S_WRITE;
          end else if (start_i) begin
            arvalid_o <= 1'b1;
            state     <= S_READ;
          end
        end
        S_WRITE: begin
          // each channel drops its valid on its own ready.
          if (awready_i) begin
            awvalid_o <= 1'b0;
          end
          if (wready_i) begin
            wvalid_o <= 1'b0;
          end
          // leave once both have been taken, in any order.
          if ((awready_i || !awvalid_o) && (wready_i || !wvalid_o)) begin
            bready_o <= 1'b1;
            state    <= S_BRESP;
          end
        end
        S_BRESP: begin
          if (bvalid_i) begin
            bready_o <= 1'b0;
            resp_o   <= bresp_i;
            done_o   <= 1'b1;
            state    <= S_IDLE;
          end
        end
        S_READ: begin
          if (arready_i) begin
            arvalid_o <= 1'b0;
            rready_o  <= 1'b1;
            state     <= S_RRESP;
          end
        end
        S_RRESP: begin
          if (rvalid_i) begin
            rready_o <= 1'b0;
            rdata_o  <= rdata_i;
            resp_o   <= rresp_i;
            done_o   <= 1'b1;
            state    <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hdl/pu_riscv_memmisaligned.sv
// flag is valid the cycle after req_i; XLEN of 32 treats every DWORD access as misaligned.
`timescale 1ns/1ps
`default_nettype none

module pu_riscv_memmisaligned #(
  parameter int XLEN    = 64,
  parameter int HAS_RVC = 1
) (
  input  wire                         clk_i,
  input  wire                         reset_i,
  input  wire                         instr_i,
  input  wire                         req_i,
  input  wire  [XLEN-1:0]             adr_i,
  input  wire  pu_riscv_mem_pkg::mem_size_t size_i,
  output logic                        misaligned_o
);

  import pu_riscv_mem_pkg::*;

  logic size_bad;
  logic align_bad;

  always_comb begin
    // unknown codes, and doublewords on a 32-bit core, never pass.
    size_bad = (size_i > DWORD) || ((XLEN == 32) && (size_i == DWORD));
    if (instr_i) begin
      // compressed code allows halfword aligned fetches.
      align_bad = (HAS_RVC != 0) ? adr_i[0] : |adr_i[1:0];
    end else begin
      // data must sit on its natural boundary.
      case (size_i)
        BYTE:    align_bad = 1'b0;
        HWORD:   align_bad = adr_i[0];
        WORD:    align_bad = |adr_i[1:0];
        default: align_bad = |adr_i[2:0];
      endcase
    end
  end

  // flag only lives for the accepted request.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      misaligned_o <= 1'b0;
    end else begin
      misaligned_o <= req_i & (size_bad | align_bad);
    end
  end

endmodule

`default_nettype wire

//--- hdl/pu_riscv_mem_pkg.sv
// access-size and AXI response codes only; size codes 4 to 7 are illegal and have no name.
`default_nettype none

package pu_riscv_mem_pkg;

  // access size as carried on the CPU request port.
  typedef logic [2:0] mem_size_t;

  // byte, halfword, word and doubleword.
  localparam mem_size_t BYTE  = 3'd0;
  localparam mem_size_t HWORD = 3'd1;
  localparam mem_size_t WORD  = 3'd2;
  localparam mem_size_t DWORD = 3'd3;

  // AXI4-Lite response, as on bresp and rresp.
  typedef logic [1:0] axi_resp_t;

  localparam axi_resp_t RESP_OKAY   = 2'b00;
  // exclusive okay is not expected from a lite slave.
  localparam axi_resp_t RESP_EXOKAY = 2'b01;
  localparam axi_resp_t RESP_SLVERR = 2'b10;
  localparam axi_resp_t RESP_DECERR = 2'b11;

endpackage

`default_nettype wire
